/* hw/spi_pkg.sv */
// SPI bus level types shared by the byte master and the CS framer
package spi_pkg;

  ////////////////////////////////////////////////////////////////////
  // Data

  typedef logic [7:0] spi_byte_t;   // One byte on MOSI or MISO

  ////////////////////////////////////////////////////////////////////
  // Modes

  // Mode | CPOL | CPHA
  //  0   |  0   |  0
  //  1   |  0   |  1
  //  2   |  1   |  0
  //  3   |  1   |  1
  // CPOL high means the clock idles high
  // CPHA high means data shifts out on the leading edge, samples on trailing
  typedef enum logic [1:0] {
    MODE0 = 2'd0,
    MODE1 = 2'd1,
    MODE2 = 2'd2,
    MODE3 = 2'd3
  } spi_mode_e;

  ////////////////////////////////////////////////////////////////////
  // Chip-select framer

  typedef enum logic [1:0] {
    CS_IDLE     = 2'd0,   // CS high, waiting for first byte
    CS_TRANSFER = 2'd1,   // CS low, bytes in flight
    CS_GAP      = 2'd2    // CS high, inactive time before next frame
  } cs_state_e;

endpackage

/* hw/devid_pkg.sv */
// Accelerometer command set and the ID reader's own types
package devid_pkg;

  // Command opcodes sent as the first byte of every transaction
  typedef enum logic [7:0] {
    OP_WRITE_REG = 8'h0A,
    OP_READ_REG  = 8'h0B,   // Address follows and data then clocks out
    OP_READ_FIFO = 8'h0D
  } dev_opcode_e;

  // Identification registers at the bottom of the map
  typedef enum logic [7:0] {
    REG_DEVID     = 8'h00,   // Vendor ID register
    REG_DEVID_MST = 8'h01,
    REG_PARTID    = 8'h02,
    REG_REVID     = 8'h03
  } dev_reg_e;

  // Opcode + address + one dummy byte
  localparam int DEVID_XFER_BYTES = 3;

  typedef enum logic [2:0] {
    SEQ_IDLE       = 3'd0,
    SEQ_SEND_CMD   = 3'd1,
    SEQ_SEND_ADDR  = 3'd2,
    SEQ_SEND_DUMMY = 3'd3,
    SEQ_WAIT_RX    = 3'd4,   // Waiting for the byte clocked out by the dummy
    SEQ_WAIT_END   = 3'd5    // Waiting for CS to rise and the gap to pass
  } seq_state_e;

  // Active-low glyph with segment a in bit 0 and segment g in bit 6
  typedef logic [6:0] seg7_t;

endpackage

/* hw/spi_byte_master.sv */
`timescale 1ns/1ns

// Shifts one byte out on MOSI and one byte in from MISO, MSB first
module spi_byte_master
  import spi_pkg::*;
#(
  parameter spi_mode_e SPI_MODE          = MODE0,
  parameter int        CLKS_PER_HALF_BIT = 2     // Must be 2 or more
)
(
  input  logic      i_Clk,
  input  logic      i_Rst_L,
  input  spi_byte_t i_tx_byte,    // Byte to send
  input  logic      i_tx_dv,      // Start pulse with i_tx_byte
  output logic      o_tx_ready,   // High while no byte is in flight
  output logic      o_rx_dv,      // One cycle, o_rx_byte complete
  output spi_byte_t o_rx_byte,
  output logic      o_spi_clk,
  input  logic      i_spi_miso,
  output logic      o_spi_mosi
);

  localparam logic CPOL = (SPI_MODE == MODE2) || (SPI_MODE == MODE3);
  localparam logic CPHA = (SPI_MODE == MODE1) || (SPI_MODE == MODE3);

  localparam int               CNT_W    = $clog2(CLKS_PER_HALF_BIT * 2);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_HALF_BIT - 1);
  localparam logic [CNT_W-1:0] FULL_END = CNT_W'(CLKS_PER_HALF_BIT * 2 - 1);
  localparam logic [4:0]       EDGES_PER_BYTE = 5'd16;   // 8 bits, two edges each

  logic [CNT_W-1:0] r_clk_cnt;    // Position inside one SPI clock period
  logic [4:0]       r_edges;      // Edges still to make for this byte
  logic             r_spi_clk;    // Internal clock, one cycle ahead of the pin
  logic             r_lead;       // Strobe, leading edge this cycle
  logic             r_trail;      // Strobe, trailing edge this cycle
  logic             r_tx_dv;      // i_tx_dv delayed to line up with r_tx_byte
  spi_byte_t        r_tx_byte;
  logic [2:0]       r_tx_bit;     // Next MOSI bit index
  logic [2:0]       r_rx_bit;     // Next MISO bit index
  logic             w_shift;
  logic             w_sample;

  // CPHA picks which edge drives and which edge samples
  assign w_shift  = CPHA ? r_lead : r_trail;
  assign w_sample = CPHA ? r_trail : r_lead;

  //////////////////////////////////////////////////////////////////////
  // SPI clock and edge strobes

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_tx_ready <= 1'b0;
      r_edges    <= '0;
      r_lead     <= 1'b0;
      r_trail    <= 1'b0;
      r_spi_clk  <= CPOL;       // Idle level
      r_clk_cnt  <= '0;
    end
    else
    begin
      r_lead  <= 1'b0;
      r_trail <= 1'b0;

      if (i_tx_dv)
      begin
        o_tx_ready <= 1'b0;
        r_edges    <= EDGES_PER_BYTE;
      end
      else if (r_edges != '0)
      begin
        o_tx_ready <= 1'b0;
        if (r_clk_cnt == FULL_END)        // End of period, trailing edge
        begin
          r_edges   <= r_edges - 1'b1;
          r_trail   <= 1'b1;
          r_clk_cnt <= '0;
          r_spi_clk <= ~r_spi_clk;
        end
        else if (r_clk_cnt == HALF_END)   // Mid period, leading edge
        begin
          r_edges   <= r_edges - 1'b1;
          r_lead    <= 1'b1;
          r_clk_cnt <= r_clk_cnt + 1'b1;
          r_spi_clk <= ~r_spi_clk;
        end
        else
        begin
          r_clk_cnt <= r_clk_cnt + 1'b1;
        end
      end
      else
      begin
        o_tx_ready <= 1'b1;               // All edges done
      end
    end
  end

  // Hold the byte, the source may change it after the pulse
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      r_tx_dv <= 1'b0;
    else
      r_tx_dv <= i_tx_dv;
  end

  always_ff @(posedge i_Clk)
  begin
    if (i_tx_dv)
      r_tx_byte <= i_tx_byte;
  end

  //////////////////////////////////////////////////////////////////////
  // MOSI

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_spi_mosi <= 1'b0;
      r_tx_bit   <= 3'd7;
    end
    else if (o_tx_ready)
    begin
      r_tx_bit <= 3'd7;                   // Rearm for MSB
    end
    else if (r_tx_dv && !CPHA)
    begin
      // CPHA 0, first bit must sit on MOSI before the first edge
      o_spi_mosi <= r_tx_byte[7];
      r_tx_bit   <= 3'd6;
    end
    else if (w_shift)
    begin
      o_spi_mosi <= r_tx_byte[r_tx_bit];
      r_tx_bit   <= r_tx_bit - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // MISO

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_rx_dv  <= 1'b0;
      r_rx_bit <= 3'd7;
    end
    else
    begin
      o_rx_dv <= 1'b0;
      if (o_tx_ready)
        r_rx_bit <= 3'd7;
      else if (w_sample)
      begin
        r_rx_bit <= r_rx_bit - 1'b1;
        if (r_rx_bit == 3'd0)
          o_rx_dv <= 1'b1;                // Eighth sample taken
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (!o_tx_ready && w_sample)
      o_rx_byte[r_rx_bit] <= i_spi_miso;
  end

  // Pin clock one cycle late so it lines up with MOSI
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_spi_clk <= CPOL;
    else
      o_spi_clk <= r_spi_clk;
  end

endmodule

/* hw/spi_cs_framer.sv */
`timescale 1ns/1ns

// Holds CS low across a fixed number of bytes, then keeps it high for a gap
module spi_cs_framer
  import spi_pkg::*;
  import devid_pkg::*;
#(
  parameter int CS_INACTIVE_CLKS = 1   // Extra cycles of CS high after a frame
)
(
  input  logic i_Clk,
  input  logic i_Rst_L,
  input  logic i_tx_dv,          // Byte start pulse, seen alongside the master
  input  logic i_master_ready,   // Byte master idle
  output logic o_tx_ready,       // Next byte may be issued
  output logic o_spi_cs_n
);

  localparam int BYTES_W = $clog2(DEVID_XFER_BYTES);
  localparam int GAP_W   = $clog2(CS_INACTIVE_CLKS + 1);

  localparam logic [BYTES_W-1:0] BYTES_AFTER_FIRST = BYTES_W'(DEVID_XFER_BYTES - 1);
  localparam logic [GAP_W-1:0]   GAP_LOAD          = GAP_W'(CS_INACTIVE_CLKS);

  cs_state_e          r_state;
  logic               r_cs_n;
  logic [BYTES_W-1:0] r_bytes_left;   // Bytes still to start in this frame
  logic [GAP_W-1:0]   r_gap_cnt;

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state      <= CS_IDLE;
      r_cs_n       <= 1'b1;        // Deselected out of reset
      r_bytes_left <= '0;
      r_gap_cnt    <= GAP_LOAD;
    end
    else
    begin
      case (r_state)
        CS_IDLE:
        begin
          if (i_tx_dv)                             // First byte opens the frame
          begin
            r_bytes_left <= BYTES_AFTER_FIRST;
            r_cs_n       <= 1'b0;
            r_state      <= CS_TRANSFER;
          end
        end
        CS_TRANSFER:
        begin
          if (i_master_ready)
          begin
            if (r_bytes_left != '0)
            begin
              if (i_tx_dv)
                r_bytes_left <= r_bytes_left - 1'b1;
            end
            else
            begin
              r_cs_n    <= 1'b1;                   // Last byte finished
              r_gap_cnt <= GAP_LOAD;
              r_state   <= CS_GAP;
            end
          end
        end
        CS_GAP:
        begin
          if (r_gap_cnt != '0)
            r_gap_cnt <= r_gap_cnt - 1'b1;
          else
            r_state <= CS_IDLE;
        end
        default:
        begin
          r_cs_n  <= 1'b1;
          r_state <= CS_IDLE;
        end
      endcase
    end
  end

  assign o_spi_cs_n = r_cs_n;

  // Low during a start pulse so the same slot is never taken twice
  assign o_tx_ready = ((r_state == CS_IDLE) ||
                       (r_state == CS_TRANSFER && i_master_ready && r_bytes_left != '0))
                      && !i_tx_dv;

endmodule

/* hw/devid_sequencer.sv */
`timescale 1ns/1ns

// Issues the register read for DEVID and captures the returned byte
module devid_sequencer
  import spi_pkg::*;
  import devid_pkg::*;
(
  input  logic      i_Clk,
  input  logic      i_Rst_L,
  input  logic      i_start,      // Level, keep reading while high
  input  logic      i_tx_ready,
  input  logic      i_rx_dv,
  input  spi_byte_t i_rx_byte,
  output spi_byte_t o_tx_byte,
  output logic      o_tx_dv,
  output spi_byte_t o_dev_id,
  output logic      o_id_done     // One cycle, o_dev_id just updated
);

  localparam spi_byte_t DUMMY_BYTE = 8'h00;   // Clocks the data byte out of the device

  localparam int                  RX_CNT_W = $clog2(DEVID_XFER_BYTES + 1);
  localparam logic [RX_CNT_W-1:0] LAST_RX  = RX_CNT_W'(DEVID_XFER_BYTES - 1);

  seq_state_e          r_state;
  logic [RX_CNT_W-1:0] r_rx_cnt;   // Bytes received so far in this frame
  spi_byte_t           r_id;       // Captured ID, shown once the frame closes

  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      r_state   <= SEQ_IDLE;
      r_rx_cnt  <= '0;
      r_id      <= '0;
      o_tx_byte <= '0;
      o_tx_dv   <= 1'b0;
      o_dev_id  <= '0;
      o_id_done <= 1'b0;
    end
    else
    begin
      o_tx_dv   <= 1'b0;                  // Pulses
      o_id_done <= 1'b0;
      if (i_rx_dv)
        r_rx_cnt <= r_rx_cnt + 1'b1;

      case (r_state)
        SEQ_IDLE:
        begin
          r_rx_cnt <= '0;
          if (i_start)
            r_state <= SEQ_SEND_CMD;
        end
        SEQ_SEND_CMD:
          if (i_tx_ready)
          begin
            o_tx_byte <= spi_byte_t'(OP_READ_REG);
            o_tx_dv   <= 1'b1;
            r_state   <= SEQ_SEND_ADDR;
          end
        SEQ_SEND_ADDR:
          if (i_tx_ready)
          begin
            o_tx_byte <= spi_byte_t'(REG_DEVID);
            o_tx_dv   <= 1'b1;
            r_state   <= SEQ_SEND_DUMMY;
          end
        SEQ_SEND_DUMMY:
          if (i_tx_ready)
          begin
            o_tx_byte <= DUMMY_BYTE;
            o_tx_dv   <= 1'b1;
            r_state   <= SEQ_WAIT_RX;
          end
        SEQ_WAIT_RX:
          if (i_rx_dv && r_rx_cnt == LAST_RX)   // Earlier bytes are only echo
          begin
            r_id    <= i_rx_byte;
            r_state <= SEQ_WAIT_END;
          end
        SEQ_WAIT_END:
          if (i_tx_ready)                        // Framer back in idle
          begin
            o_dev_id  <= r_id;
            o_id_done <= 1'b1;
            r_state   <= SEQ_IDLE;
          end
        default:
          r_state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

/* hw/hex_seg_decoder.sv */
`timescale 1ns/1ns

// Hex digit to active-low seven-segment glyph
module hex_seg_decoder
  import devid_pkg::*;
(
  input  logic [3:0] i_nibble,
  output seg7_t      o_seg      // gfedcba, low lights the segment
);

  always_comb
  begin
    case (i_nibble)
      4'h0: o_seg = 7'b1000000;
      4'h1: o_seg = 7'b1111001;
      4'h2: o_seg = 7'b0100100;
      4'h3: o_seg = 7'b0110000;
      4'h4: o_seg = 7'b0011001;
      4'h5: o_seg = 7'b0010010;
      4'h6: o_seg = 7'b0000010;
      4'h7: o_seg = 7'b1111000;
      4'h8: o_seg = 7'b0000000;   // All on
      4'h9: o_seg = 7'b0010000;
      4'hA: o_seg = 7'b0001000;
      4'hB: o_seg = 7'b0000011;   // Lower case b
      4'hC: o_seg = 7'b1000110;
      4'hD: o_seg = 7'b0100001;   // Lower case d
      4'hE: o_seg = 7'b0000110;
      4'hF: o_seg = 7'b0001110;
      default: o_seg = 7'b1111111;
    endcase
  end

endmodule

/* hw/devid_reader_top.sv */
`timescale 1ns/1ns

// Accelerometer ID reader, SPI chain plus two hex displays
module devid_reader_top
  import spi_pkg::*;
  import devid_pkg::*;
#(
  parameter spi_mode_e SPI_MODE          = MODE0,
  parameter int        CLKS_PER_HALF_BIT = 250,
  parameter int        CS_INACTIVE_CLKS  = 2
)
(
  input  logic      i_Clk,
  input  logic      i_Rst_L,
  input  logic      i_start,
  input  logic      i_spi_miso,
  output logic      o_spi_clk,
  output logic      o_spi_mosi,
  output logic      o_spi_cs_n,
  output spi_byte_t o_dev_id,
  output logic      o_id_done,
  output seg7_t     o_hex0,      // Low nibble
  output seg7_t     o_hex1       // High nibble
);

  spi_byte_t w_tx_byte;
  logic      w_tx_dv;
  logic      w_tx_ready;       // Framer view, gates the sequencer
  logic      w_master_ready;   // Byte master idle
  logic      w_rx_dv;
  spi_byte_t w_rx_byte;

  devid_sequencer seq_i (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_start    (i_start),
    .i_tx_ready (w_tx_ready),
    .i_rx_dv    (w_rx_dv),
    .i_rx_byte  (w_rx_byte),
    .o_tx_byte  (w_tx_byte),
    .o_tx_dv    (w_tx_dv),
    .o_dev_id   (o_dev_id),
    .o_id_done  (o_id_done)
  );

  spi_cs_framer #(
    .CS_INACTIVE_CLKS (CS_INACTIVE_CLKS)
  ) framer_i (
    .i_Clk          (i_Clk),
    .i_Rst_L        (i_Rst_L),
    .i_tx_dv        (w_tx_dv),
    .i_master_ready (w_master_ready),
    .o_tx_ready     (w_tx_ready),
    .o_spi_cs_n     (o_spi_cs_n)
  );

  spi_byte_master #(
    .SPI_MODE          (SPI_MODE),
    .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
  ) master_i (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx_byte  (w_tx_byte),
    .i_tx_dv    (w_tx_dv),
    .o_tx_ready (w_master_ready),
    .o_rx_dv    (w_rx_dv),
    .o_rx_byte  (w_rx_byte),
    .o_spi_clk  (o_spi_clk),
    .i_spi_miso (i_spi_miso),
    .o_spi_mosi (o_spi_mosi)
  );

  hex_seg_decoder hex0_i (
    .i_nibble (o_dev_id[3:0]),
    .o_seg    (o_hex0)
  );

  hex_seg_decoder hex1_i (
    .i_nibble (o_dev_id[7:4]),
    .o_seg    (o_hex1)
  );

endmodule

/* dv/spi_slave_model.sv */
`timescale 1ns/1ns

// Behavioral mode 0 SPI peripheral, returns i_dev_id on the third byte
module spi_slave_model
  import spi_pkg::*;
(
  input  logic      i_spi_clk,
  input  logic      i_spi_cs_n,
  input  logic      i_spi_mosi,
  output logic      o_spi_miso,
  input  spi_byte_t i_dev_id,       // Latched when CS falls
  output int        o_frames,       // Completed CS low periods
  output int        o_last_bytes,   // Whole bytes in the last frame, -1 if a byte was cut
  output spi_byte_t o_cmd0,         // MOSI bytes of the last frame
  output spi_byte_t o_cmd1,
  output spi_byte_t o_cmd2
);

  initial
  begin
    logic [23:0] out_sr;    // Echo, echo, ID, MSB first
    spi_byte_t   in_sr;
    int          bits;
    int          bytes;
    o_spi_miso   = 1'b1;
    o_frames     = 0;
    o_last_bytes = 0;
    o_cmd0       = '0;
    o_cmd1       = '0;
    o_cmd2       = '0;
    forever
    begin
      @(negedge i_spi_cs_n);
      out_sr     = {8'hFF, 8'hFF, i_dev_id};
      o_spi_miso = out_sr[23];             // CPHA 0, first bit ready at select
      in_sr      = '0;
      bits       = 0;
      bytes      = 0;
      while (!i_spi_cs_n)
      begin
        @(i_spi_clk or posedge i_spi_cs_n);
        if (i_spi_cs_n)
          break;
        if (i_spi_clk)
        begin
          // Rising edge, sample MOSI
          in_sr = {in_sr[6:0], i_spi_mosi};
          bits  = bits + 1;
          if (bits == 8)
          begin
            if (bytes == 0) o_cmd0 = in_sr;
            if (bytes == 1) o_cmd1 = in_sr;
            if (bytes == 2) o_cmd2 = in_sr;
            bytes = bytes + 1;
            bits  = 0;
          end
        end
        else
        begin
          out_sr     = out_sr << 1;         // Falling edge, next MISO bit
          o_spi_miso = out_sr[23];
        end
      end
      o_last_bytes = (bits == 0) ? bytes : -1;
      o_frames     = o_frames + 1;
      o_spi_miso   = 1'b1;
    end
  end

endmodule

/* dv/tb_devid_reader.sv */
`timescale 1ns/1ns

// Testbench for the accelerometer ID reader
module tb_devid_reader
  import spi_pkg::*;
  import devid_pkg::*;
;

  localparam int NUM_ROWS    = 7;
  localparam int TIMEOUT     = NUM_ROWS * 400 + 100;   // Cycles
  localparam int IDLE_CYCLES = 300;
  localparam int DRIVE_DLY   = 2;                      // ns after rising edge
  localparam int MIN_GAP     = 3;                      // CS_INACTIVE_CLKS + 1

  logic      r_clk;
  logic      r_rst_l;
  logic      r_start;
  spi_byte_t r_model_id;    // ID the slave model answers with
  logic      w_miso;
  logic      w_sclk;
  logic      w_mosi;
  logic      w_cs_n;
  spi_byte_t w_dev_id;
  logic      w_id_done;
  seg7_t     w_hex0;
  seg7_t     w_hex1;
  int        w_frames;
  int        w_last_bytes;
  spi_byte_t w_cmd0;
  spi_byte_t w_cmd1;
  spi_byte_t w_cmd2;

  spi_byte_t row_id    [NUM_ROWS];   // Stimulus table
  logic      row_start [NUM_ROWS];
  int        cycles = 0;
  int        cs_high_cnt = 0;
  logic      seen_frame = 1'b0;
  spi_byte_t prev_dev_id = '0;

  devid_reader_top #(
    .SPI_MODE          (MODE0),
    .CLKS_PER_HALF_BIT (4),
    .CS_INACTIVE_CLKS  (2)
  ) dut_i (
    .i_Clk      (r_clk),
    .i_Rst_L    (r_rst_l),
    .i_start    (r_start),
    .i_spi_miso (w_miso),
    .o_spi_clk  (w_sclk),
    .o_spi_mosi (w_mosi),
    .o_spi_cs_n (w_cs_n),
    .o_dev_id   (w_dev_id),
    .o_id_done  (w_id_done),
    .o_hex0     (w_hex0),
    .o_hex1     (w_hex1)
  );

  spi_slave_model slave_i (
    .i_spi_clk    (w_sclk),
    .i_spi_cs_n   (w_cs_n),
    .i_spi_mosi   (w_mosi),
    .o_spi_miso   (w_miso),
    .i_dev_id     (r_model_id),
    .o_frames     (w_frames),
    .o_last_bytes (w_last_bytes),
    .o_cmd0       (w_cmd0),
    .o_cmd1       (w_cmd1),
    .o_cmd2       (w_cmd2)
  );

  initial
  begin
    r_clk = 1'b0;
    forever #10 r_clk = ~r_clk;   // 20 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // Checks

  task automatic stop_on_error();
    $display("Some tests failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t exp);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s is %02h, expected %02h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_seg(input string name, input seg7_t got, input seg7_t exp);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s is %07b, expected %07b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // Active-low gfedcba glyphs
  function automatic seg7_t glyph_for(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'b1000000;
      4'h1: return 7'b1111001;
      4'h2: return 7'b0100100;
      4'h3: return 7'b0110000;
      4'h4: return 7'b0011001;
      4'h5: return 7'b0010010;
      4'h6: return 7'b0000010;
      4'h7: return 7'b1111000;
      4'h8: return 7'b0000000;
      4'h9: return 7'b0010000;
      4'hA: return 7'b0001000;
      4'hB: return 7'b0000011;
      4'hC: return 7'b1000110;
      4'hD: return 7'b0100001;
      4'hE: return 7'b0000110;
      default: return 7'b0001110;
    endcase
  endfunction

  task automatic check_display(input spi_byte_t id);
    check_byte("o_dev_id", w_dev_id, id);
    check_seg("o_hex0", w_hex0, glyph_for(id[3:0]));
    check_seg("o_hex1", w_hex1, glyph_for(id[7:4]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitors

  always @(posedge r_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT)
    begin
      $display("Run took longer than %0d cycles, DUT stopped responding", TIMEOUT);
      $display("Some tests failed");
      $fatal(1, "Timeout");
    end
  end

  // CS gap between frames and ID stability
  always @(negedge r_clk)
  begin
    if (r_rst_l)
    begin
      if (w_cs_n)
        cs_high_cnt = cs_high_cnt + 1;
      else
      begin
        if (seen_frame && cs_high_cnt != 0 && cs_high_cnt < MIN_GAP)
        begin
          $display("CS was high for only %0d cycles between frames at %0t ns",
                   cs_high_cnt, $time);
          stop_on_error();
        end
        seen_frame  = 1'b1;
        cs_high_cnt = 0;
      end
      if (w_dev_id !== prev_dev_id && !w_id_done)
      begin
        $display("o_dev_id changed without o_id_done at %0t ns", $time);
        stop_on_error();
      end
      prev_dev_id = w_dev_id;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  initial
  begin
    int exp_frames;
    exp_frames = 0;
    r_rst_l    = 1'b0;
    r_start    = 1'b0;
    r_model_id = '0;
    void'($urandom(32'h6038_62c9));
    // ID and start level per row with row 3 left idle
    row_id[0]    = 8'h00;
    row_start[0] = 1'b1;
    row_id[1]    = 8'hAD;
    row_start[1] = 1'b1;
    row_id[2]    = 8'hF2;
    row_start[2] = 1'b1;
    row_id[3]    = 8'h00;
    row_start[3] = 1'b0;
    row_id[4]    = 8'h5E;
    row_start[4] = 1'b1;
    row_id[5]    = spi_byte_t'($urandom());
    row_start[5] = 1'b1;
    row_id[6]    = spi_byte_t'($urandom());
    row_start[6] = 1'b1;

    repeat (8) @(posedge r_clk);
    #DRIVE_DLY r_rst_l = 1'b1;

    @(negedge r_clk);
    check_bit("o_spi_cs_n", w_cs_n, 1'b1);
    check_bit("o_id_done", w_id_done, 1'b0);
    check_bit("o_spi_clk", w_sclk, 1'b0);   // Mode 0 idles low
    check_display(8'h00);

    for (int i = 0; i < NUM_ROWS; i++)
    begin
      if (!row_start[i])
      begin
        repeat (IDLE_CYCLES)
        begin
          @(negedge r_clk);
          check_bit("o_spi_cs_n", w_cs_n, 1'b1);
          check_bit("o_id_done", w_id_done, 1'b0);
        end
      end
      else
      begin
        if (!r_start)
        begin
          @(posedge r_clk);
          #DRIVE_DLY;
          r_model_id = row_id[i];
          r_start    = 1'b1;
        end
        do @(negedge r_clk); while (w_cs_n);    // Frame has begun
        // Model has latched its ID so the next row can be set up
        @(posedge r_clk);
        #DRIVE_DLY;
        if (i + 1 < NUM_ROWS)
        begin
          r_start = row_start[i+1];
          if (row_start[i+1])
            r_model_id = row_id[i+1];
        end
        else
          r_start = 1'b0;
        do @(negedge r_clk); while (!w_id_done);
        exp_frames = exp_frames + 1;
        check_display(row_id[i]);
        check_count("frames seen by slave", w_frames, exp_frames);
        check_count("bytes in frame", w_last_bytes, DEVID_XFER_BYTES);
        check_byte("MOSI byte 0", w_cmd0, 8'h0B);
        check_byte("MOSI byte 1", w_cmd1, 8'h00);
        check_byte("MOSI byte 2", w_cmd2, 8'h00);
      end
    end

    repeat (4) @(posedge r_clk);
    $display("All tests passed");
    $finish;
  end

endmodule

/* devid_reader_top.f */
hw/spi_pkg.sv
hw/devid_pkg.sv
hw/spi_byte_master.sv
hw/spi_cs_framer.sv
hw/devid_sequencer.sv
hw/hex_seg_decoder.sv
hw/devid_reader_top.sv
dv/spi_slave_model.sv
dv/tb_devid_reader.sv

/* Makefile */
TB_TOP := tb_devid_reader

all: run

run: obj_dir/V$(TB_TOP)
	./obj_dir/V$(TB_TOP)

obj_dir/V$(TB_TOP): devid_reader_top.f $(wildcard hw/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --top-module $(TB_TOP) -f devid_reader_top.f -o V$(TB_TOP)

lint:
	verilator --lint-only -Wall --top-module devid_reader_top \
	  hw/spi_pkg.sv hw/devid_pkg.sv hw/spi_byte_master.sv hw/spi_cs_framer.sv \
	  hw/devid_sequencer.sv hw/hex_seg_decoder.sv hw/devid_reader_top.sv

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
